/* verilog/stdPkg.sv */
`default_nettype none

package stdPkg;

    // Instruction and fetch widths
    localparam int halfWidth = 32;
    localparam int wordWidth = 64;

    // Standard field widths
    localparam int regWidth  = 4;
    localparam int opcWidth  = 8;
    localparam int idxWidth  = 4;
    localparam int dispWidth = 16;

    // Native escape, real opcode sits in disp high byte
    localparam logic [opcWidth-1:0] escapeOpcode = 8'h3F;

    // All ones register field
    localparam logic [regWidth-1:0] reg15Value = 4'hF;

    // Native layout, opcode first
    typedef struct packed {
        logic [opcWidth-1:0]  opcode;
        logic [regWidth-1:0]  register;
        logic [idxWidth-1:0]  index;
        logic [dispWidth-1:0] disp;
    } nativeFmt_t;

    // Emulated layout, register first
    typedef struct packed {
        logic [regWidth-1:0]  register;
        logic [opcWidth-1:0]  opcode;
        logic [idxWidth-1:0]  modifier;
        logic [dispWidth-1:0] disp;
    } emulFmt_t;

    // Same word, read per pe
    typedef union packed {
        nativeFmt_t native;
        emulFmt_t   emul;
    } instrHalf_t;

endpackage

`default_nettype wire

/* verilog/halfWordIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface halfWordIf;

    stdPkg::instrHalf_t half;     // Selected instruction half
    logic               pe;       // Format of the held word
    logic               strobe;   // One cycle per decode
    logic               present;  // Word loaded since reset

    modport source (
        output half,
        output pe,
        output strobe,
        output present
    );

    modport sink (
        input half,
        input pe,
        input strobe,
        input present
    );

endinterface

`default_nettype wire

/* verilog/fetchBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchBuffer (
    input wire                         clk,
    input wire                         rstN,
    input wire                         load,
    input wire [stdPkg::wordWidth-1:0] word,
    input wire                         pe,
    input wire                         decode,
    input wire                         tkk,
    halfWordIf.source                  hw
);

    logic [stdPkg::wordWidth-1:0] wordReg;
    logic                         peReg;
    logic                         loaded;

    logic [stdPkg::halfWidth-1:0] lowHalf;
    logic [stdPkg::halfWidth-1:0] highHalf;

    // Payload only
    always_ff @(posedge clk) begin
        if (load) begin
            wordReg <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            peReg  <= 1'b0;
            loaded <= 1'b0;
        end else if (load) begin
            peReg  <= pe;
            loaded <= 1'b1;   // Sticky until reset
        end
    end

    assign lowHalf  = wordReg[stdPkg::halfWidth-1:0];
    assign highHalf = wordReg[stdPkg::wordWidth-1:stdPkg::halfWidth];

    // A load in the same cycle shows up only after the edge
    always_comb begin
        if (tkk) begin
            hw.half = lowHalf;    // tkk 1 picks low half
        end else begin
            hw.half = highHalf;
        end
    end

    assign hw.pe      = peReg;
    assign hw.strobe  = decode;
    assign hw.present = loaded;

endmodule

`default_nettype wire

/* verilog/standardizer.sv */
`timescale 1ns/10ps
`default_nettype none

module standardizer (
    input wire                               clk,
    input wire                               rstN,
    halfWordIf.sink                          hw,
    output logic                             outValid,
    output logic                             noWord,
    output logic [stdPkg::regWidth-1:0]      regField,
    output logic                             reg15,
    output logic [stdPkg::opcWidth-1:0]      opcode,
    output logic [stdPkg::idxWidth-1:0]      indexField,
    output logic [stdPkg::dispWidth-1:0]     disp,
    output logic                             extended
);

    stdPkg::nativeFmt_t natFmt;
    stdPkg::emulFmt_t   emuFmt;

    logic [stdPkg::regWidth-1:0]  natReg;
    logic [stdPkg::opcWidth-1:0]  natOpc;
    logic [stdPkg::idxWidth-1:0]  natIdx;
    logic [stdPkg::dispWidth-1:0] natDisp;
    logic                         natExt;

    logic [stdPkg::regWidth-1:0]  emuReg;
    logic [stdPkg::opcWidth-1:0]  emuOpc;
    logic [stdPkg::idxWidth-1:0]  emuIdx;
    logic [stdPkg::dispWidth-1:0] emuDisp;

    logic [stdPkg::regWidth-1:0]  selReg;
    logic [stdPkg::opcWidth-1:0]  selOpc;
    logic [stdPkg::idxWidth-1:0]  selIdx;
    logic [stdPkg::dispWidth-1:0] selDisp;
    logic                         selExt;
    logic                         selReg15;

    logic                         takeFields;

    // Two views of the same half
    assign natFmt = hw.half.native;
    assign emuFmt = hw.half.emul;

    // Native format, escape check on the opcode byte
    always_comb begin
        natReg  = natFmt.register;
        natIdx  = natFmt.index;
        natDisp = natFmt.disp;
        natExt  = (natFmt.opcode == stdPkg::escapeOpcode);
        if (natExt) begin
            natOpc = natFmt.disp[stdPkg::dispWidth-1 -: stdPkg::opcWidth];
        end else begin
            natOpc = natFmt.opcode;
        end
    end

    // Emulated format never escapes
    always_comb begin
        emuReg  = emuFmt.register;
        emuOpc  = emuFmt.opcode;
        emuIdx  = emuFmt.modifier;     // Lands in the index slot
        emuDisp = emuFmt.disp;
    end

    always_comb begin
        if (hw.pe) begin
            selReg  = emuReg;
            selOpc  = emuOpc;
            selIdx  = emuIdx;
            selDisp = emuDisp;
            selExt  = 1'b0;
        end else begin
            selReg  = natReg;
            selOpc  = natOpc;
            selIdx  = natIdx;
            selDisp = natDisp;
            selExt  = natExt;
        end
    end

    assign selReg15   = (selReg == stdPkg::reg15Value);
    assign takeFields = hw.strobe & hw.present;

    // Status pulses, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            noWord   <= 1'b0;
        end else begin
            outValid <= takeFields;
            noWord   <= hw.strobe & ~hw.present;
        end
    end

    // Fields hold when nothing was loaded
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regField   <= '0;
            reg15      <= 1'b0;
            opcode     <= '0;
            indexField <= '0;
            disp       <= '0;
            extended   <= 1'b0;
        end else if (takeFields) begin
            regField   <= selReg;
            reg15      <= selReg15;
            opcode     <= selOpc;
            indexField <= selIdx;
            disp       <= selDisp;     // Passed unchanged even when extended
            extended   <= selExt;
        end
    end

endmodule

`default_nettype wire

/* verilog/frontEnd.sv */
`timescale 1ns/10ps
`default_nettype none

module frontEnd (
    input wire                            clk,
    input wire                            rstN,
    input wire                            load,
    input wire  [stdPkg::wordWidth-1:0]   word,
    input wire                            pe,
    input wire                            decode,
    input wire                            tkk,
    output logic                          outValid,
    output logic                          noWord,
    output logic [stdPkg::regWidth-1:0]   regField,
    output logic                          reg15,
    output logic [stdPkg::opcWidth-1:0]   opcode,
    output logic [stdPkg::idxWidth-1:0]   indexField,
    output logic [stdPkg::dispWidth-1:0]  disp,
    output logic                          extended
);

    halfWordIf hw0 ();   // Buffer to standardizer

    fetchBuffer buffer0 (
        .clk    (clk),
        .rstN   (rstN),
        .load   (load),
        .word   (word),
        .pe     (pe),
        .decode (decode),
        .tkk    (tkk),
        .hw     (hw0.source)
    );

    standardizer std0 (
        .clk        (clk),
        .rstN       (rstN),
        .hw         (hw0.sink),
        .outValid   (outValid),
        .noWord     (noWord),
        .regField   (regField),
        .reg15      (reg15),
        .opcode     (opcode),
        .indexField (indexField),
        .disp       (disp),
        .extended   (extended)
    );

endmodule

`default_nettype wire

/* dv/frontEnd_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module frontEndAssertions (
    input wire                        clk,
    input wire                        rstN,
    input wire                        load,
    input wire                        pe,
    input wire                        decode,
    input wire                        outValid,
    input wire                        noWord,
    input wire [stdPkg::regWidth-1:0] regField,
    input wire                        reg15,
    input wire                        extended
);

    int   failCount = 0;
    logic heldPe;
    logic loaded;

    // Mirror of the buffered mode and loaded flag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            heldPe <= 1'b0;
            loaded <= 1'b0;
        end else if (load) begin
            heldPe <= pe;
            loaded <= 1'b1;
        end
    end

    statusExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(outValid && noWord))
        else begin
            $error("outValid and noWord high together");
            failCount++;
        end

    strobeAnswered: assert property (@(posedge clk) disable iff (!rstN)
        decode |=> (outValid ^ noWord))
        else begin
            $error("decode not answered by exactly one status pulse");
            failCount++;
        end

    pulseHasStrobe: assert property (@(posedge clk) disable iff (!rstN)
        (outValid || noWord) |-> $past(decode))
        else begin
            $error("status pulse without a decode one cycle before");
            failCount++;
        end

    reg15Consistent: assert property (@(posedge clk) disable iff (!rstN)
        reg15 |-> (regField == stdPkg::reg15Value))
        else begin
            $error("reg15 high with register field not all ones");
            failCount++;
        end

    emulNeverExtended: assert property (@(posedge clk) disable iff (!rstN)
        (decode && loaded && heldPe) |=> !extended)
        else begin
            $error("extended raised for an emulated decode");
            failCount++;
        end

endmodule

`default_nettype wire

/* dv/frontEndTb.sv */
`timescale 1ns/10ps
`default_nettype none

module frontEndTb;

    localparam int waitLimit = 20;

    logic                           clk;
    logic                           rstN;
    logic                           load;
    logic [stdPkg::wordWidth-1:0]   word;
    logic                           pe;
    logic                           decode;
    logic                           tkk;
    logic                           outValid;
    logic                           noWord;
    logic [stdPkg::regWidth-1:0]    regField;
    logic                           reg15;
    logic [stdPkg::opcWidth-1:0]    opcode;
    logic [stdPkg::idxWidth-1:0]    indexField;
    logic [stdPkg::dispWidth-1:0]   disp;
    logic                           extended;

    logic [31:0] rngState;
    logic [63:0] heldWord;      // Model of the fetch buffer
    logic        heldPe;
    logic        heldLoaded;
    logic [63:0] randWords [4];
    int          checks;
    int          errors;

    frontEnd dut0 (
        .clk(clk), .rstN(rstN), .load(load), .word(word), .pe(pe),
        .decode(decode), .tkk(tkk), .outValid(outValid), .noWord(noWord),
        .regField(regField), .reg15(reg15), .opcode(opcode),
        .indexField(indexField), .disp(disp), .extended(extended)
    );

    bind frontEnd frontEndAssertions asrt0 (
        .clk(clk), .rstN(rstN), .load(load), .pe(pe), .decode(decode),
        .outValid(outValid), .noWord(noWord), .regField(regField),
        .reg15(reg15), .extended(extended)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] stepRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextWord(output logic [63:0] w);
        logic [31:0] hi;
        rngState = stepRandom(rngState);
        hi = rngState;
        rngState = stepRandom(rngState);
        w = {hi, rngState};
    endtask

    // Field rules per format
    task automatic refFields(input logic [31:0] h, input logic p,
            output logic [3:0] r, output logic [7:0] o, output logic [3:0] i,
            output logic [15:0] d, output logic e);
        d = h[15:0];
        i = h[19:16];
        if (p) begin
            r = h[31:28];
            o = h[27:20];
            e = 1'b0;
        end else begin
            r = h[23:20];
            e = (h[31:24] == stdPkg::escapeOpcode);
            o = e ? h[15:8] : h[31:24];   // Escape takes the disp high byte
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic loadWord(input logic [63:0] w, input logic p);
        load = 1'b1;
        word = w;
        pe = p;
        nextCycle();
        load = 1'b0;
        heldWord = w;
        heldPe = p;
        heldLoaded = 1'b1;
    endtask

    task automatic waitResult(output int latency);
        latency = 1;
        while (!(outValid || noWord) && latency < waitLimit) begin
            nextCycle();
            latency++;
        end
        assert (outValid || noWord) else begin
            $display("Timeout: no outValid or noWord within %0d cycles", waitLimit);
            errors++;
        end
    endtask

    task automatic checkFields(input logic [31:0] h, input logic p);
        logic [3:0]  r;
        logic [7:0]  o;
        logic [3:0]  i;
        logic [15:0] d;
        logic        e;
        refFields(h, p, r, o, i, d, e);
        checkValue("outValid", 32'(outValid), 32'd1);
        checkValue("noWord", 32'(noWord), 32'd0);
        checkValue("regField", 32'(regField), 32'(r));
        checkValue("reg15", 32'(reg15), 32'(r == 4'hF));
        checkValue("opcode", 32'(opcode), 32'(o));
        checkValue("indexField", 32'(indexField), 32'(i));
        checkValue("disp", 32'(disp), 32'(d));
        checkValue("extended", 32'(extended), 32'(e));
    endtask

    task automatic decodeAndCheck(input logic t);
        logic [31:0] h;
        int          latency;
        h = t ? heldWord[31:0] : heldWord[63:32];   // tkk 1 is the low half
        decode = 1'b1;
        tkk = t;
        nextCycle();
        decode = 1'b0;
        waitResult(latency);
        checkValue("latency", 32'(latency), 32'd1);
        if (heldLoaded) begin
            checkFields(h, heldPe);
        end else begin
            checkValue("noWord", 32'(noWord), 32'd1);
            checkValue("outValid", 32'(outValid), 32'd0);
        end
    endtask

    task automatic testNoWord();
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("noWord", 32'(noWord), 32'd0);
        decodeAndCheck(1'b1);
        decodeAndCheck(1'b0);
        checkValue("opcode", 32'(opcode), 32'd0);   // Fields keep reset values
        checkValue("disp", 32'(disp), 32'd0);
        checkValue("extended", 32'(extended), 32'd0);
    endtask

    task automatic testNative();
        for (int k = 0; k < 4; k++) begin
            nextWord(randWords[k]);
            loadWord(randWords[k], 1'b0);
            decodeAndCheck(1'b1);
            decodeAndCheck(1'b0);
        end
    endtask

    task automatic testEmulated();
        for (int k = 0; k < 4; k++) begin
            loadWord(randWords[k], 1'b1);
            decodeAndCheck(1'b1);
            decodeAndCheck(1'b0);
        end
    endtask

    task automatic testEscape();
        logic [63:0] esc;
        esc = {8'h3F, 4'h2, 4'h5, 16'hA7C4, 8'h12, 4'h3, 4'h4, 16'h0F0F};
        loadWord(esc, 1'b0);
        decodeAndCheck(1'b0);
        checkValue("extended", 32'(extended), 32'd1);
        checkValue("opcode", 32'(opcode), 32'h0A7);
        decodeAndCheck(1'b1);
        checkValue("extended", 32'(extended), 32'd0);
        loadWord(esc, 1'b1);
        decodeAndCheck(1'b0);
        checkValue("extended", 32'(extended), 32'd0);
    endtask

    task automatic testReg15();
        loadWord({8'h10, 4'hF, 4'h0, 16'h1234, 8'h11, 4'h7, 4'h1, 16'h4321}, 1'b0);
        decodeAndCheck(1'b0);
        checkValue("reg15", 32'(reg15), 32'd1);
        decodeAndCheck(1'b1);
        checkValue("reg15", 32'(reg15), 32'd0);
        loadWord({4'hF, 8'h22, 4'h3, 16'h5678, 4'hE, 8'h23, 4'h4, 16'h8765}, 1'b1);
        decodeAndCheck(1'b0);
        checkValue("reg15", 32'(reg15), 32'd1);
        decodeAndCheck(1'b1);
        checkValue("reg15", 32'(reg15), 32'd0);
    endtask

    task automatic testBackToBack();
        logic [63:0] oldWord;
        logic [63:0] newWord;
        nextWord(oldWord);
        nextWord(newWord);
        loadWord(oldWord, 1'b0);
        decode = 1'b1;
        for (int k = 0; k < 4; k++) begin
            tkk = k[0];
            nextCycle();
            checkFields(k[0] ? oldWord[31:0] : oldWord[63:32], 1'b0);
        end
        // Load with decode still sees the old word and mode
        load = 1'b1;
        word = newWord;
        pe = 1'b1;
        tkk = 1'b0;
        nextCycle();
        load = 1'b0;
        decode = 1'b0;
        checkFields(oldWord[63:32], 1'b0);
        heldWord = newWord;
        heldPe = 1'b1;
        decodeAndCheck(1'b0);
    endtask

    initial begin
        rngState = 32'h6ad2d5e3;
        checks = 0;
        errors = 0;
        heldWord = '0;
        heldPe = 1'b0;
        heldLoaded = 1'b0;
        rstN = 1'b0;
        load = 1'b0;
        word = '0;
        pe = 1'b0;
        decode = 1'b0;
        tkk = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        testNoWord();
        testNative();
        testEmulated();
        testEscape();
        testReg15();
        testBackToBack();

        $display("Checks %0d, errors %0d, assertion failures %0d",
            checks, errors, dut0.asrt0.failCount);
        if (errors == 0 && dut0.asrt0.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/stdPkg.sv
verilog/halfWordIf.sv
verilog/fetchBuffer.sv
verilog/standardizer.sv
verilog/frontEnd.sv
dv/frontEnd_assertions.sv
dv/frontEndTb.sv

/* run.sh */
#!/bin/sh
# Build and run the frontEnd testbench with Verilator, verdict from sim.log
rm -f sim.log \
    && verilator --binary --timing --assert --top-module frontEndTb -f project.f \
    && ./obj_dir/VfrontEndTb +verilator+error+limit+100 2>&1 | tee sim.log \
    || echo "Build or run failed" > sim.log
grep -q ">>> PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
